// File: Makefile
# Verilator build and run for the dense layer testbench

VERILATOR = verilator
TOP = denseLayerTb
FILELIST = denseLayer.f
BUILD_DIR = obj_dir
FLAGS = --binary --timing --assert -j 0
SIM = $(BUILD_DIR)/V$(TOP)

SOURCES = $(wildcard rtl/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A failing run ends in $$fatal, which gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: denseLayer.f
+incdir+include
rtl/layer_pkg.sv
rtl/weightStore.sv
rtl/reluNeuron.sv
rtl/argmaxSelect.sv
rtl/denseLayer.sv
dv/denseLayer_sva.sv
dv/denseLayerTb.sv

// File: dv/denseLayerTb.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module denseLayerTb;
	import layer_pkg::*;

	typedef struct packed
	{
		layerOut_t layerOut;
		neuronIndex_t classIndex;
		act_t classScore;
	} expected_t;

	// Four full coefficient loads plus two writes past the bias
	localparam int writeCount = 4 * `NEURON_COUNT * (`IN_COUNT + 1) + 2;
	localparam int vectorCount = 66;
	localparam int cycleLimit = 2 * (writeCount + vectorCount + 4) + 50;

	logic clk;
	logic reset;
	logic weightWrite;
	weightWrite_t weightReq;
	logic inValid;
	actVector_t actIn;
	logic outValid;
	layerOut_t layerOut;
	neuronIndex_t classIndex;
	act_t classScore;

	neuronCoefs_t [`NEURON_COUNT-1:0] coefModel; // Mirror of the weight store
	expected_t expQ[$];
	integer seed = 32'hd8d1_cf50;
	int cycleCount = 0;

	denseLayer UUT
	(
		.clk(clk),
		.reset(reset),
		.weightWrite(weightWrite),
		.weightReq(weightReq),
		.inValid(inValid),
		.actIn(actIn),
		.outValid(outValid),
		.layerOut(layerOut),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Wrapped dot product plus bias, ReLU on bit 15, then the first maximum
	function automatic expected_t referenceOut(input actVector_t v);
		expected_t e;
		int sum;
		e = '0;
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			sum = int'($signed(coefModel[n].bias));
			for (int k = 0; k < `IN_COUNT; k++)
			begin
				sum = sum + int'($signed(v.act[k])) * int'($signed(coefModel[n].weight[k]));
			end
			e.layerOut.neuron[n] = sum[15] ? 16'h0000 : sum[15:0];
		end
		e.classScore = e.layerOut.neuron[0];
		for (int n = 1; n < `NEURON_COUNT; n++)
		begin
			if (e.layerOut.neuron[n] > e.classScore)
			begin
				e.classIndex = neuronIndex_t'(n);
				e.classScore = e.layerOut.neuron[n];
			end
		end
		return e;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic writeCoef(input int n, input int index, input coef_t value);
		@(posedge clk);
		inValid <= 1'b0;
		weightWrite <= 1'b1;
		weightReq <= '{neuron: neuronIndex_t'(n), index: weightIndex_t'(index), data: value};
		if (index < `IN_COUNT)
		begin
			coefModel[n].weight[index] = value;
		end
		else if (index == `IN_COUNT)
		begin
			coefModel[n].bias = value;
		end
	endtask

	// Weight k of the neuron gets base + k * step
	task automatic loadNeuron(input int n, input int base, input int step, input int bias);
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			writeCoef(n, k, coef_t'(base + k * step));
		end
		writeCoef(n, `IN_COUNT, coef_t'(bias));
	endtask

	task automatic sendVector(input actVector_t v);
		@(posedge clk);
		weightWrite <= 1'b0;
		inValid <= 1'b1;
		actIn <= v;
		expQ.push_back(referenceOut(v));
	endtask

	task automatic drainPipeline();
		@(posedge clk);
		inValid <= 1'b0;
		weightWrite <= 1'b0;
		while (expQ.size() != 0)
		begin
			@(posedge clk);
		end
	endtask

	// Outputs are sampled half a cycle after the edge that updates them
	always @(negedge clk)
	begin
		expected_t e;
		if (outValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				$display("outValid went high with no vector outstanding at %0t", $time);
				$display("=== FAIL ===");
				$fatal(1, "Unexpected output");
			end
			else
			begin
				e = expQ.pop_front();
				for (int n = 0; n < `NEURON_COUNT; n++)
				begin
					checkValue($sformatf("layerOut.neuron[%0d]", n), e.layerOut.neuron[n],
						layerOut.neuron[n]);
				end
				checkValue("classIndex", 16'(e.classIndex), 16'(classIndex));
				checkValue("classScore", e.classScore, classScore);
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		actVector_t v;
		reset = 1'b1;
		weightWrite = 1'b0;
		weightReq = '0;
		inValid = 1'b0;
		actIn = '0;
		coefModel = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		repeat (5) @(posedge clk); // Idle, nothing may come out
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			v.act[k] = act_t'($random(seed));
		end
		sendVector(v); // Cleared weights give all zeros
		drainPipeline();

		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			loadNeuron(n, n - 2, n + 1, 5 * n - 8);
		end
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			v.act[k] = act_t'(k - 3);
		end
		sendVector(v);
		drainPipeline();

		// Negative sum, sum past bit 15, sum wrapping back positive, product wrap
		loadNeuron(0, 1, 0, -2000);
		loadNeuron(1, 30, 0, 0);
		loadNeuron(2, 50, 0, 0);
		loadNeuron(3, 400, 0, 20000);
		v = '{act: '{default: 16'd200}};
		sendVector(v);
		v = '{act: '{default: 16'hfffd}};
		sendVector(v);
		drainPipeline();

		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			for (int k = 0; k <= `IN_COUNT; k++)
			begin
				writeCoef(n, k, coef_t'($random(seed)));
			end
		end
		for (int i = 0; i < 60; i++)
		begin
			for (int k = 0; k < `IN_COUNT; k++)
			begin
				v.act[k] = act_t'($random(seed));
			end
			sendVector(v);
		end
		drainPipeline();

		// Neurons 1 and 2 tie for the maximum
		loadNeuron(0, 1, 0, 0);
		loadNeuron(1, 3, 1, 7);
		loadNeuron(2, 3, 1, 7);
		loadNeuron(3, 2, 0, 0);
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			v.act[k] = act_t'(k + 1);
		end
		sendVector(v);
		drainPipeline();
		writeCoef(1, `IN_COUNT + 1, 16'h7fff);
		writeCoef(2, 15, 16'h4000);
		sendVector(v);
		@(posedge clk);
		inValid <= 1'b0;

		repeat (5) @(posedge clk); // The last vector leaves the pipeline within these edges
		if (expQ.size() != 0)
		begin
			$display("Expected results were left over at the end of the run");
			$display("=== FAIL ===");
			$fatal(1, "Queue not empty");
		end
		else
		begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// File: dv/denseLayer_sva.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module denseLayer_sva
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input layer_pkg::layerOut_t layerOut,
	input layer_pkg::neuronIndex_t classIndex,
	input layer_pkg::act_t classScore
);
	logic scoreIsMax;

	always_comb
	begin
		scoreIsMax = 1'b1;
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			if (layerOut.neuron[n] > classScore)
			begin
				scoreIsMax = 1'b0;
			end
		end
	end

	quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !outValid)
		else $error("outValid high in the cycle after reset");

	// Four register stages from input to output
	fixedLatency: assert property (@(posedge clk) disable iff (reset)
		outValid == $past(inValid, 4))
		else $error("outValid does not follow inValid by 4 cycles");

	scoreMatchesIndex: assert property (@(posedge clk) disable iff (reset)
		outValid |-> classScore == layerOut.neuron[classIndex])
		else $error("classScore differs from the selected neuron output");

	scoreIsLargest: assert property (@(posedge clk) disable iff (reset)
		outValid |-> scoreIsMax)
		else $error("A neuron output exceeds classScore");

endmodule

bind denseLayer denseLayer_sva uSva
(
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.outValid(outValid),
	.layerOut(layerOut),
	.classIndex(classIndex),
	.classScore(classScore)
);

// File: include/layer_macros.svh
`ifndef LAYER_MACROS_SVH
`define LAYER_MACROS_SVH

// One word of the datapath, two's complement with wrap-around
`define ACT_WIDTH 16

`define IN_COUNT 8 // Activations per input vector
`define NEURON_COUNT 4

`define NEURON_INDEX_WIDTH 2
// Index IN_COUNT addresses the bias of a neuron
`define WEIGHT_INDEX_WIDTH 4

`endif

// File: rtl/argmaxSelect.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module argmaxSelect
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input layer_pkg::layerOut_t results,
	output logic outValid,
	output layer_pkg::layerOut_t layerOut,
	output layer_pkg::neuronIndex_t classIndex,
	output layer_pkg::act_t classScore
);
	import layer_pkg::*;

	neuronIndex_t bestIndex;
	act_t bestScore;

	// ReLU outputs are never negative, so an unsigned compare orders them
	always_comb
	begin
		bestIndex = '0;
		bestScore = results.neuron[0];
		for (int n = 1; n < `NEURON_COUNT; n++)
		begin
			// Strictly greater keeps the lowest index on a tie
			if (results.neuron[n] > bestScore)
			begin
				bestIndex = neuronIndex_t'(n);
				bestScore = results.neuron[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// The class outputs hold between vectors
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layerOut <= '0;
			classIndex <= '0;
			classScore <= '0;
		end
		else if (inValid)
		begin
			layerOut <= results;
			classIndex <= bestIndex;
			classScore <= bestScore;
		end
	end

endmodule

// File: rtl/denseLayer.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module denseLayer
(
	input logic clk,
	input logic reset,
	input logic weightWrite,
	input layer_pkg::weightWrite_t weightReq,
	input logic inValid,
	input layer_pkg::actVector_t actIn,
	output logic outValid,
	output layer_pkg::layerOut_t layerOut,
	output layer_pkg::neuronIndex_t classIndex,
	output layer_pkg::act_t classScore
);
	import layer_pkg::*;

	neuronCoefs_t [`NEURON_COUNT-1:0] coefs;
	layerOut_t results;
	logic [`NEURON_COUNT-1:0] neuronValid;

	weightStore uWeightStore
	(
		.clk(clk),
		.reset(reset),
		.weightWrite(weightWrite),
		.weightReq(weightReq),
		.coefs(coefs)
	);

	for (genvar n = 0; n < `NEURON_COUNT; n++)
	begin : gNeuron
		reluNeuron uNeuron
		(
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.actIn(actIn),
			.coefs(coefs[n]),
			.result(results.neuron[n]),
			.resultValid(neuronValid[n])
		);
	end

	// All neurons run in lockstep, so neuron 0 speaks for the layer
	argmaxSelect uArgmax
	(
		.clk(clk),
		.reset(reset),
		.inValid(neuronValid[0]),
		.results(results),
		.outValid(outValid),
		.layerOut(layerOut),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

// File: rtl/layer_pkg.sv
`include "layer_macros.svh"

package layer_pkg;

	typedef logic [`ACT_WIDTH-1:0] act_t; // Activation or sum
	typedef logic [`ACT_WIDTH-1:0] coef_t; // Weight or bias

	typedef logic [`NEURON_INDEX_WIDTH-1:0] neuronIndex_t;
	typedef logic [`WEIGHT_INDEX_WIDTH-1:0] weightIndex_t;

	typedef struct packed
	{
		act_t [`IN_COUNT-1:0] act;
	} actVector_t;

	// Everything one neuron needs besides its input vector
	typedef struct packed
	{
		coef_t [`IN_COUNT-1:0] weight;
		coef_t bias;
	} neuronCoefs_t;

	typedef struct packed
	{
		act_t [`NEURON_COUNT-1:0] neuron;
	} layerOut_t;

	typedef struct packed
	{
		neuronIndex_t neuron;
		weightIndex_t index; // 0 to IN_COUNT-1 for a weight, IN_COUNT for the bias
		coef_t data;
	} weightWrite_t;

endpackage

// File: rtl/reluNeuron.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module reluNeuron
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input layer_pkg::actVector_t actIn,
	input layer_pkg::neuronCoefs_t coefs,
	output layer_pkg::act_t result,
	output logic resultValid
);
	import layer_pkg::*;

	actVector_t actReg;
	logic actValid;
	act_t [`IN_COUNT-1:0] products;
	act_t sumNext;
	act_t sumReg;
	logic sumValid;

	// Edge 1 captures the input vector
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			actValid <= 1'b0;
		end
		else
		begin
			actReg <= actIn;
			actValid <= inValid;
		end
	end

	// Only the low word of each product is kept
	always_comb
	begin
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			products[k] = actReg.act[k] * coefs.weight[k];
		end
	end

	always_comb
	begin
		sumNext = coefs.bias;
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			sumNext = sumNext + products[k]; // Wraps modulo 2^16
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			sumValid <= 1'b0;
		end
		else
		begin
			sumReg <= sumNext;
			sumValid <= actValid;
		end
	end

	// ReLU looks only at the sign bit of the wrapped sum
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			result <= sumReg[`ACT_WIDTH-1] ? '0 : sumReg;
			resultValid <= sumValid;
		end
	end

endmodule

// File: rtl/weightStore.sv
`timescale 1ns/1ps
`include "layer_macros.svh"

module weightStore
(
	input logic clk,
	input logic reset,
	input logic weightWrite,
	input layer_pkg::weightWrite_t weightReq,
	output layer_pkg::neuronCoefs_t [`NEURON_COUNT-1:0] coefs
);
	import layer_pkg::*;

	logic [`NEURON_COUNT-1:0] neuronSel;
	logic [`IN_COUNT-1:0] weightSel;
	logic biasSel;
	logic writeAccept;
	neuronCoefs_t [`NEURON_COUNT-1:0] coefReg;

	// One-hot select of the neuron that owns the write
	always_comb
	begin
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			neuronSel[n] = (weightReq.neuron == neuronIndex_t'(n));
		end
	end

	// Coefficient decode within the neuron
	always_comb
	begin
		for (int k = 0; k < `IN_COUNT; k++)
		begin
			weightSel[k] = (weightReq.index == weightIndex_t'(k));
		end
		biasSel = (weightReq.index == weightIndex_t'(`IN_COUNT));
	end

	// An index past the bias hits nothing and the write is dropped
	assign writeAccept = weightWrite && (biasSel || (|weightSel));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			coefReg <= '0;
		end
		else if (writeAccept)
		begin
			for (int n = 0; n < `NEURON_COUNT; n++)
			begin
				for (int k = 0; k < `IN_COUNT; k++)
				begin
					if (neuronSel[n] && weightSel[k])
					begin
						coefReg[n].weight[k] <= weightReq.data;
					end
				end
				if (neuronSel[n] && biasSel)
				begin
					coefReg[n].bias <= weightReq.data;
				end
			end
		end
	end

	// Every neuron sees its coefficients straight from the registers
	assign coefs = coefReg;

endmodule
